/* hdl/cache_pkg.sv */
// address split, line geometry and controller states of the two-way data cache
// referenced by scoped name from the cache modules
`default_nettype none

package cache_pkg;

  localparam int addr_w = 16;
  localparam int data_w = 16;

  // address is tag | index | word | byte
  localparam int tag_w      = 5;   // bits 15..11
  localparam int index_w    = 8;   // bits 10..3
  localparam int offset_w   = 3;   // bits 2..0, bit 0 always zero
  localparam int word_sel_w = 2;   // bits 2..1

  localparam int words_per_line = 4;
  localparam int num_sets       = 1 << index_w;

  // encoding is sequential, so the write-back and fetch
  // states step with state + 1
  typedef enum logic [3:0] {
    st_idle     = 4'h0,
    st_cmp_rd   = 4'h1,
    st_cmp_wr   = 4'h2,
    st_wb0      = 4'h3,
    st_wb1      = 4'h4,
    st_wb2      = 4'h5,
    st_wb3      = 4'h6,
    st_alloc0   = 4'h7,
    st_alloc1   = 4'h8,
    st_alloc2   = 4'h9,
    st_alloc3   = 4'ha,
    st_alloc4   = 4'hb,   // wait for the last word
    st_commit   = 4'hc,   // last word in, line valid
    st_rd_retry = 4'hd,
    st_wr_retry = 4'he,
    st_err      = 4'hf
  } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/mem_pkg.sv */
// geometry of the banked main memory behind the cache
`default_nettype none

package mem_pkg;

  localparam int num_banks  = 4;
  localparam int bank_sel_w = $clog2(num_banks);  // address bits 2..1

  localparam int mem_words  = 32768;              // 16-bit words, 64 KB
  localparam int bank_depth = mem_words / num_banks;

endpackage

`default_nettype wire

/* hdl/cache_way.sv */
// one way of the data cache, 256 lines of four words with tag, valid and dirty
// compare mode checks the tag, access mode reads or fills a line word by word
`default_nettype none

module cache_way (
  input  wire                              clk,
  input  wire                              arst_n,
  input  wire                              enable,
  input  wire                              comp,
  input  wire                              write,
  input  wire                              valid_in,
  input  wire [cache_pkg::tag_w-1:0]       tag_in,
  input  wire [cache_pkg::index_w-1:0]     index,
  input  wire [cache_pkg::word_sel_w-1:0]  word,
  input  wire [cache_pkg::data_w-1:0]      wdata,
  output logic                             hit,
  output logic                             valid,
  output logic                             dirty,
  output logic [cache_pkg::tag_w-1:0]      tag_out,
  output logic [cache_pkg::data_w-1:0]     rdata
);

  logic [cache_pkg::num_sets-1:0] valid_q;
  logic [cache_pkg::num_sets-1:0] dirty_q;
  logic [cache_pkg::tag_w-1:0]    tag_mem [cache_pkg::num_sets];
  logic [cache_pkg::data_w-1:0]   data_mem [cache_pkg::num_sets][cache_pkg::words_per_line];

  logic wr_hit;
  logic wr_fill;

  // combinational lookup
  assign valid   = valid_q[index];
  assign dirty   = valid_q[index] & dirty_q[index];  // stale dirty of an empty line hidden
  assign tag_out = tag_mem[index];
  assign rdata   = data_mem[index][word];
  assign hit     = comp & valid & (tag_mem[index] == tag_in);

  assign wr_hit  = enable & write & hit;    // store word on a hit, line turns dirty
  assign wr_fill = enable & write & ~comp;  // line fill from memory

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (wr_fill) begin
      valid_q[index] <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hit || wr_fill) begin
      data_mem[index][word] <= wdata;
    end
    if (wr_hit) begin
      dirty_q[index] <= 1'b1;
    end else if (wr_fill) begin
      dirty_q[index] <= 1'b0;   // fresh copy of memory
      tag_mem[index] <= tag_in;
    end
  end

endmodule

`default_nettype wire

/* hdl/way_select.sv */
// steers the two cache ways: hit way or victim way, write enables per way
// and the status the controller checks in its compare cycle
`default_nettype none

module way_select (
  input  wire                              clk,
  input  wire                              arst_n,
  input  var cache_pkg::ctrl_state_t       state,
  input  wire                              enable,
  input  wire                              hit0,
  input  wire                              valid0,
  input  wire                              dirty0,
  input  wire                              hit1,
  input  wire                              valid1,
  input  wire                              dirty1,
  input  wire [cache_pkg::tag_w-1:0]       tag0,
  input  wire [cache_pkg::tag_w-1:0]       tag1,
  input  wire [cache_pkg::data_w-1:0]      rdata0,
  input  wire [cache_pkg::data_w-1:0]      rdata1,
  input  wire                              stall,
  output logic                             en0,
  output logic                             en1,
  output logic [cache_pkg::data_w-1:0]     sel_rdata,
  output logic [cache_pkg::tag_w-1:0]      sel_tag,
  output logic                             sel_hit,
  output logic                             sel_valid,
  output logic                             sel_dirty
);

  logic victim_q;  // global round robin bit
  logic fill_q;    // way picked for the current miss
  logic lookup;
  logic fill_way;
  logic way_sel;

  // states that address the ways with the full request
  assign lookup = state inside {cache_pkg::st_idle, cache_pkg::st_cmp_rd,
                                cache_pkg::st_cmp_wr, cache_pkg::st_rd_retry,
                                cache_pkg::st_wr_retry};

  // empty way first, then the victim bit
  assign fill_way = !valid0 ? 1'b0 : (!valid1 ? 1'b1 : victim_q);

  always_comb begin
    if (!lookup)   way_sel = fill_q;  // write-back and fill stay on one way
    else if (hit0) way_sel = 1'b0;
    else if (hit1) way_sel = 1'b1;
    else           way_sel = fill_way;
  end

  // a compare write only lands in the hitting way
  assign en0 = enable & (lookup | ~fill_q);
  assign en1 = enable & (lookup | fill_q);

  assign sel_rdata = way_sel ? rdata1 : rdata0;
  assign sel_tag   = way_sel ? tag1 : tag0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      victim_q  <= 1'b0;
      fill_q    <= 1'b0;
      sel_hit   <= 1'b0;
      sel_valid <= 1'b0;
      sel_dirty <= 1'b0;
    end else begin
      if (state == cache_pkg::st_cmp_rd || state == cache_pkg::st_cmp_wr) begin
        victim_q <= ~victim_q;  // every compare, hit or miss
      end
      if (!stall) begin
        fill_q    <= fill_way;  // snapshot of the set as seen in idle
        sel_hit   <= way_sel ? hit1 : hit0;
        sel_valid <= way_sel ? valid1 : valid0;
        sel_dirty <= way_sel ? dirty1 : dirty0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/cache_ctrl.sv */
// cache controller FSM: compare, write-back of a dirty victim, line fetch,
// commit and retry; also rejects misused requests
`default_nettype none

module cache_ctrl #(
  parameter int mem_latency = 4
) (
  input  wire                              clk,
  input  wire                              arst_n,
  input  wire                              rd,
  input  wire                              wr,
  input  wire [cache_pkg::addr_w-1:0]      addr,
  input  wire [cache_pkg::data_w-1:0]      data_in,
  input  wire                              sel_hit,
  input  wire                              sel_valid,
  input  wire                              sel_dirty,
  input  wire [cache_pkg::tag_w-1:0]       sel_tag,
  input  wire [cache_pkg::data_w-1:0]      sel_rdata,
  input  wire [cache_pkg::data_w-1:0]      mem_rdata,
  input  wire                              mem_stall,
  output cache_pkg::ctrl_state_t           state,
  output logic                             way_en,
  output logic                             comp,
  output logic                             write,
  output logic                             valid_in,
  output logic [cache_pkg::tag_w-1:0]      tag_in,
  output logic [cache_pkg::index_w-1:0]    index,
  output logic [cache_pkg::word_sel_w-1:0] ctrl_word,
  output logic [cache_pkg::data_w-1:0]     way_wdata,
  output logic                             mem_rd,
  output logic                             mem_wr,
  output logic [cache_pkg::addr_w-1:0]     mem_addr,
  output logic [cache_pkg::data_w-1:0]     mem_wdata,
  output logic                             done,
  output logic                             stall,
  output logic                             cache_hit,
  output logic                             err
);

  localparam int tag_lsb = cache_pkg::offset_w + cache_pkg::index_w;

  cache_pkg::ctrl_state_t state_nxt;

  logic                             misuse;
  logic                             cmp;
  logic                             retry;
  logic                             hit_now;
  logic                             commit;
  logic [mem_latency-1:0]           rd_pipe;   // outstanding reads by age
  logic                             ret;
  logic                             ret_last;
  logic [cache_pkg::word_sel_w-1:0] ret_cnt;   // next word to install
  logic [cache_pkg::word_sel_w-1:0] issue_word;
  logic [cache_pkg::data_w-1:0]     last_word;

  assign tag_in  = addr[tag_lsb +: cache_pkg::tag_w];
  assign index   = addr[cache_pkg::offset_w +: cache_pkg::index_w];
  assign misuse  = (rd & wr) | ((rd | wr) & addr[0]);

  assign cmp     = state inside {cache_pkg::st_cmp_rd, cache_pkg::st_cmp_wr};
  assign retry   = state inside {cache_pkg::st_rd_retry, cache_pkg::st_wr_retry};
  assign commit  = (state == cache_pkg::st_commit);
  assign hit_now = cmp & sel_hit;

  assign mem_wr = state inside {cache_pkg::st_wb0, cache_pkg::st_wb1,
                                cache_pkg::st_wb2, cache_pkg::st_wb3};
  assign mem_rd = state inside {cache_pkg::st_alloc0, cache_pkg::st_alloc1,
                                cache_pkg::st_alloc2, cache_pkg::st_alloc3};

  // returned words come back in issue order
  assign ret      = rd_pipe[mem_latency-1];
  assign ret_last = ret & (ret_cnt == '1);

  always_comb begin
    case (state)
      cache_pkg::st_wb1, cache_pkg::st_alloc1: issue_word = 2'd1;
      cache_pkg::st_wb2, cache_pkg::st_alloc2: issue_word = 2'd2;
      cache_pkg::st_wb3, cache_pkg::st_alloc3: issue_word = 2'd3;
      default:                                 issue_word = 2'd0;
    endcase
  end

  // way side
  assign way_en = (state != cache_pkg::st_err);
  assign comp   = cmp | retry | (state == cache_pkg::st_idle);
  assign write  = (state == cache_pkg::st_cmp_wr) | (state == cache_pkg::st_wr_retry)
                | commit | (ret & ~ret_last);
  assign valid_in = commit;

  always_comb begin
    if (comp)        ctrl_word = addr[1 +: cache_pkg::word_sel_w];
    else if (mem_wr) ctrl_word = issue_word;  // victim word going out
    else if (commit) ctrl_word = '1;
    else             ctrl_word = ret_cnt;
  end

  assign way_wdata = comp ? data_in : (commit ? last_word : mem_rdata);

  // memory side, victim line goes to its own tag
  assign mem_addr  = mem_wr ? {sel_tag, index, issue_word, 1'b0}
                            : {addr[cache_pkg::addr_w-1:cache_pkg::offset_w], issue_word, 1'b0};
  assign mem_wdata = sel_rdata;

  // requester side
  assign cache_hit = hit_now;
  assign err       = (state == cache_pkg::st_err);
  assign done      = hit_now | retry | err;
  assign stall     = (state != cache_pkg::st_idle) & ~hit_now;

  always_comb begin
    state_nxt = state;
    case (state)
      cache_pkg::st_idle: begin
        if (misuse)  state_nxt = cache_pkg::st_err;
        else if (rd) state_nxt = cache_pkg::st_cmp_rd;
        else if (wr) state_nxt = cache_pkg::st_cmp_wr;
      end
      cache_pkg::st_cmp_rd, cache_pkg::st_cmp_wr: begin
        if (sel_hit)                    state_nxt = cache_pkg::st_idle;
        else if (sel_valid & sel_dirty) state_nxt = cache_pkg::st_wb0;
        else                            state_nxt = cache_pkg::st_alloc0;
      end
      cache_pkg::st_wb0, cache_pkg::st_wb1, cache_pkg::st_wb2, cache_pkg::st_wb3,
      cache_pkg::st_alloc0, cache_pkg::st_alloc1, cache_pkg::st_alloc2,
      cache_pkg::st_alloc3: begin
        if (!mem_stall) state_nxt = cache_pkg::ctrl_state_t'(state + 4'd1);  // busy bank, retry
      end
      cache_pkg::st_alloc4: begin
        if (ret_last) state_nxt = cache_pkg::st_commit;
      end
      cache_pkg::st_commit: begin
        state_nxt = wr ? cache_pkg::st_wr_retry : cache_pkg::st_rd_retry;
      end
      default: state_nxt = cache_pkg::st_idle;  // retry and error end here
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= cache_pkg::st_idle;
      rd_pipe <= '0;
      ret_cnt <= '0;
    end else begin
      state   <= state_nxt;
      rd_pipe <= (rd_pipe << 1) | mem_latency'(mem_rd & ~mem_stall);
      if (ret) ret_cnt <= ret_cnt + 1'b1;  // wraps after the fourth word
    end
  end

  // last word waits here for the commit write
  always_ff @(posedge clk) begin
    if (ret_last) last_word <= mem_rdata;
  end

endmodule

`default_nettype wire

/* hdl/banked_mem.sv */
// four-bank main memory, bank picked by address bits 2..1
// reads return after mem_latency cycles, a bank stays busy as long after any access
`default_nettype none

module banked_mem #(
  parameter int mem_latency = 4
) (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire [cache_pkg::addr_w-1:0]  addr,
  input  wire [cache_pkg::data_w-1:0]  wdata,
  input  wire                          rd,
  input  wire                          wr,
  output logic [cache_pkg::data_w-1:0] rdata,
  output logic                         stall
);

  localparam int row_w = $clog2(mem_pkg::bank_depth);
  localparam int cnt_w = $clog2(mem_latency + 1);

  logic [mem_pkg::bank_sel_w-1:0] bank;
  logic [row_w-1:0]               row;
  logic [mem_pkg::num_banks-1:0]  busy;
  logic [cache_pkg::data_w-1:0]   bank_rdata [mem_pkg::num_banks];

  assign bank  = addr[1 +: mem_pkg::bank_sel_w];
  assign row   = addr[1 + mem_pkg::bank_sel_w +: row_w];
  assign stall = (rd | wr) & busy[bank];  // access dropped, requester retries

  for (genvar b = 0; b < mem_pkg::num_banks; b++) begin : g_bank
    logic [cache_pkg::data_w-1:0] arr [mem_pkg::bank_depth] = '{default: '0};
    logic [cnt_w-1:0]             busy_cnt;
    logic [cache_pkg::data_w-1:0] pipe [mem_latency];
    logic [mem_latency-1:0]       pipe_vld;
    logic                         access;

    assign access        = (rd | wr) & ~stall & (bank == b);
    assign busy[b]       = (busy_cnt != '0);
    assign bank_rdata[b] = pipe_vld[mem_latency-1] ? pipe[mem_latency-1] : '0;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        busy_cnt <= '0;
        pipe_vld <= '0;
      end else begin
        if (access)       busy_cnt <= cnt_w'(mem_latency);
        else if (busy[b]) busy_cnt <= busy_cnt - 1'b1;
        pipe_vld <= (pipe_vld << 1) | mem_latency'(access & rd);
      end
    end

    // write lands at the strobe edge
    always_ff @(posedge clk) begin
      if (access && wr) arr[row] <= wdata;
      pipe[0] <= arr[row];
      for (int i = 1; i < mem_latency; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  // at most one bank returns in a cycle
  always_comb begin
    rdata = '0;
    for (int b = 0; b < mem_pkg::num_banks; b++) begin
      rdata = rdata | bank_rdata[b];
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_system.sv */
// top of the cached memory system: controller, two ways, way selection, main memory
// the requester holds rd or wr with address and data until done
`default_nettype none

module mem_system #(
  parameter int mem_latency = 4
) (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire [cache_pkg::addr_w-1:0]  addr,
  input  wire [cache_pkg::data_w-1:0]  data_in,
  input  wire                          rd,
  input  wire                          wr,
  output logic [cache_pkg::data_w-1:0] data_out,
  output logic                         done,
  output logic                         stall,
  output logic                         cache_hit,
  output logic                         err
);

  cache_pkg::ctrl_state_t state;

  // controller to ways
  logic                             way_en, comp, write, valid_in;
  logic [cache_pkg::tag_w-1:0]      tag_in;
  logic [cache_pkg::index_w-1:0]    index;
  logic [cache_pkg::word_sel_w-1:0] ctrl_word;
  logic [cache_pkg::data_w-1:0]     way_wdata;

  // ways to selection
  logic                             en0, en1;
  logic                             hit0, valid0, dirty0, hit1, valid1, dirty1;
  logic [cache_pkg::tag_w-1:0]      tag0, tag1, sel_tag;
  logic [cache_pkg::data_w-1:0]     rdata0, rdata1;
  logic                             sel_hit, sel_valid, sel_dirty;

  // controller to memory
  logic                             mem_rd, mem_wr, mem_stall;
  logic [cache_pkg::addr_w-1:0]     mem_addr;
  logic [cache_pkg::data_w-1:0]     mem_wdata, mem_rdata;

  cache_ctrl #(.mem_latency(mem_latency)) ctrl0 (
    .clk, .arst_n, .rd, .wr, .addr, .data_in,
    .sel_hit, .sel_valid, .sel_dirty, .sel_tag, .sel_rdata(data_out),
    .mem_rdata, .mem_stall,
    .state, .way_en, .comp, .write, .valid_in, .tag_in, .index, .ctrl_word, .way_wdata,
    .mem_rd, .mem_wr, .mem_addr, .mem_wdata,
    .done, .stall, .cache_hit, .err
  );

  cache_way way0 (
    .clk, .arst_n, .enable(en0), .comp, .write, .valid_in, .tag_in, .index,
    .word(ctrl_word), .wdata(way_wdata),
    .hit(hit0), .valid(valid0), .dirty(dirty0), .tag_out(tag0), .rdata(rdata0)
  );

  cache_way way1 (
    .clk, .arst_n, .enable(en1), .comp, .write, .valid_in, .tag_in, .index,
    .word(ctrl_word), .wdata(way_wdata),
    .hit(hit1), .valid(valid1), .dirty(dirty1), .tag_out(tag1), .rdata(rdata1)
  );

  way_select sel0 (
    .clk, .arst_n, .state, .enable(way_en),
    .hit0, .valid0, .dirty0, .hit1, .valid1, .dirty1,
    .tag0, .tag1, .rdata0, .rdata1, .stall,
    .en0, .en1, .sel_rdata(data_out), .sel_tag, .sel_hit, .sel_valid, .sel_dirty
  );

  banked_mem #(.mem_latency(mem_latency)) mem0 (
    .clk, .arst_n, .addr(mem_addr), .wdata(mem_wdata), .rd(mem_rd), .wr(mem_wr),
    .rdata(mem_rdata), .stall(mem_stall)
  );

endmodule

`default_nettype wire

/* sim/tb_mem_system.sv */
// testbench for the cached memory system: random reads, writes and misused
// requests checked against a reference two-way cache with its own main memory
`default_nettype none

module tb_mem_system;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int mem_latency  = 4;
  localparam int period       = 40;
  localparam int num_req      = 400;
  localparam int directed_req = 8;
  localparam int worst_miss   = 60;   // cycles, dirty miss with bank stalls
  localparam int watchdog_ns  = (num_req + directed_req + 4) * worst_miss * period;

  logic        clk;
  logic        arst_n;
  logic [15:0] addr;
  logic [15:0] data_in;
  logic        rd;
  logic        wr;
  logic [15:0] data_out;
  logic        done;
  logic        stall;
  logic        cache_hit;
  logic        err;

  // reference state
  logic [15:0]                 ref_mem [mem_pkg::mem_words];
  logic [cache_pkg::tag_w-1:0] ref_tag [2][cache_pkg::num_sets];
  logic                        ref_valid [2][cache_pkg::num_sets];
  logic                        ref_dirty [2][cache_pkg::num_sets];
  logic [15:0]                 ref_data [2][cache_pkg::num_sets][cache_pkg::words_per_line];
  logic                        ref_victim;

  // few tags over few sets, so lines keep getting evicted
  logic [4:0] tag_pool [4] = '{5'h03, 5'h0a, 5'h11, 5'h1e};
  logic [7:0] index_pool [3] = '{8'h00, 8'h5c, 8'hff};

  mem_system #(.mem_latency(mem_latency)) dut0 (
    .clk, .arst_n, .addr, .data_in, .rd, .wr,
    .data_out, .done, .stall, .cache_hit, .err
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s = %h, expected %h at %0t ns", name, got, exp, $time);
      stop_on_failure();
    end
  endtask

  task automatic reset_reference();
    for (int i = 0; i < mem_pkg::mem_words; i++) ref_mem[i] = '0;
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < cache_pkg::num_sets; s++) begin
        ref_tag[w][s]   = '0;
        ref_valid[w][s] = 1'b0;
        ref_dirty[w][s] = 1'b0;
        for (int k = 0; k < cache_pkg::words_per_line; k++) ref_data[w][s][k] = '0;
      end
    end
    ref_victim = 1'b0;
  endtask

  // one legal access on the reference cache: hit check, victim rule, write-back, fill
  task automatic predict_access(input logic is_wr, input logic [15:0] a,
                                input logic [15:0] wdata, output logic hit,
                                output logic [15:0] rdata);
    logic [4:0] t;
    logic [7:0] idx;
    logic [1:0] w;
    int         way;
    t   = a[15:11];
    idx = a[10:3];
    w   = a[2:1];
    hit = 1'b1;
    if (ref_valid[0][idx] && ref_tag[0][idx] == t) way = 0;
    else if (ref_valid[1][idx] && ref_tag[1][idx] == t) way = 1;
    else begin
      hit = 1'b0;
      if (!ref_valid[0][idx]) way = 0;       // empty way first
      else if (!ref_valid[1][idx]) way = 1;
      else way = int'(ref_victim);
      if (ref_valid[way][idx] && ref_dirty[way][idx]) begin
        for (int k = 0; k < 4; k++) begin
          ref_mem[{ref_tag[way][idx], idx, 2'(k)}] = ref_data[way][idx][k];
        end
      end
      for (int k = 0; k < 4; k++) ref_data[way][idx][k] = ref_mem[{t, idx, 2'(k)}];
      ref_tag[way][idx]   = t;
      ref_valid[way][idx] = 1'b1;
      ref_dirty[way][idx] = 1'b0;
    end
    ref_victim = ~ref_victim;  // every compare
    if (is_wr) begin
      ref_data[way][idx][w] = wdata;
      ref_dirty[way][idx]   = 1'b1;
    end
    rdata = ref_data[way][idx][w];
  endtask

  // present one request on a falling edge and hold it until done
  task automatic run_request(input logic do_rd, input logic do_wr,
                             input logic [15:0] a, input logic [15:0] wdata);
    logic        misuse;
    logic        exp_hit;
    logic [15:0] exp_data;
    int          cycles;
    misuse   = (do_rd && do_wr) || a[0];
    exp_hit  = 1'b0;
    exp_data = '0;
    if (!misuse) predict_access(do_wr, a, wdata, exp_hit, exp_data);
    @(negedge clk);
    rd      = do_rd;
    wr      = do_wr;
    addr    = a;
    data_in = wdata;
    cycles  = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > worst_miss) begin
        $display("request at address %h got no done within %0d cycles", a, worst_miss);
        stop_on_failure();
      end
      if (!done) check_value("stall", stall, 1);  // busy until done
    end while (!done);
    if (misuse) begin
      check_value("err", err, 1);
      check_value("cache_hit", cache_hit, 0);
      check_value("done latency", cycles, 1);
    end else begin
      check_value("err", err, 0);
      check_value("cache_hit", cache_hit, exp_hit);
      check_value("stall", stall, !exp_hit);
      if (exp_hit) check_value("done latency", cycles, 1);
      if (do_rd) check_value("data_out", data_out, exp_data);
    end
  endtask

  function automatic logic [15:0] random_addr();
    return {tag_pool[$urandom_range(3)], index_pool[$urandom_range(2)],
            2'($urandom_range(3)), 1'b0};
  endfunction

  // dirty line pushed out by three other tags, then read back through memory
  task automatic evict_and_reread();
    logic [15:0] a0;
    a0 = {tag_pool[0], index_pool[1], 2'd2, 1'b0};
    run_request(1'b0, 1'b1, a0, 16'hbeef);
    for (int i = 1; i < 4; i++) begin
      run_request(1'b1, 1'b0, {tag_pool[i], index_pool[1], 2'd2, 1'b0}, 16'h0000);
    end
    run_request(1'b1, 1'b0, a0, 16'h0000);
    run_request(1'b1, 1'b1, a0, 16'h1234);       // both strobes
    run_request(1'b0, 1'b1, a0 | 16'h1, 16'h5678);  // odd address
    run_request(1'b1, 1'b0, a0, 16'h0000);       // still the old value
  endtask

  initial begin
    #(watchdog_ns);
    $display("watchdog: run did not finish within %0d ns", watchdog_ns);
    stop_on_failure();
  end

  initial begin : main
    int          kind;
    logic [15:0] a;
    logic [15:0] d;
    void'($urandom(32'h711a_1084));
    arst_n    = 1'b0;
    rd        = 1'b0;
    wr        = 1'b0;
    addr      = '0;
    data_in   = '0;
    reset_reference();
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_value("done", done, 0);
    check_value("err", err, 0);
    check_value("stall", stall, 0);
    check_value("cache_hit", cache_hit, 0);

    evict_and_reread();

    for (int n = 0; n < num_req; n++) begin
      kind = $urandom_range(99);
      a    = random_addr();
      d    = 16'($urandom);
      if (kind < 4) run_request(1'b1, 1'b1, a, d);
      else if (kind < 8) run_request(kind % 2 == 0, kind % 2 != 0, a | 16'h1, d);
      else if (kind < 55) run_request(1'b1, 1'b0, a, d);
      else run_request(1'b0, 1'b1, a, d);
    end

    @(negedge clk);
    rd = 1'b0;
    wr = 1'b0;
    repeat (2) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/cache_way.sv
hdl/way_select.sv
hdl/cache_ctrl.sv
hdl/banked_mem.sv
hdl/mem_system.sv
sim/tb_mem_system.sv

/* Makefile */
# Verilator build for the two-way cache and its testbench

TOOL     = verilator
FLAGS    = --timing
SIMFLAGS = --binary -Wno-fatal
TOP      = tb_mem_system
FILELIST = vlog.f
OBJ_DIR  = obj_dir
PASS_MSG = PASS: all tests

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only when the testbench printed its pass line
sim:
	$(TOOL) $(SIMFLAGS) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
